// ==== Makefile ====
# Verilator build and run for the bfloat16 divider

VERILATOR ?= verilator
TOP       ?= bf16_div_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===
SIM       ?= $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message appears in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/bf16_div_clkgen.sv ====
`timescale 1ns/1ns

module bf16_div_clkgen (
	output logic clk,
	output logic rst
);

	// 40 ns clock
	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 16;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset released on a rising edge
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== dv/bf16_div_tb.sv ====
`timescale 1ns/1ns

module bf16_div_tb;

	// room for 400 operations of 40 cycles each plus reset
	localparam int CYCLE_LIMIT = 400 * 40 + 16;

	logic clk;
	logic rst;
	logic in_req;
	logic in_ack;
	logic [15:0] a;
	logic [15:0] b;
	logic out_req;
	logic out_ack;
	logic [15:0] result;

	// receiver holds off acknowledging while set
	logic hold_ack;
	logic out_req_prev = 1'b0;

	// expected words and test names in request order
	logic [15:0] expect_q[$];
	string name_q[$];

	logic [31:0] lfsr = 32'h94fc382f;
	int sent = 0;
	// every rise of out_req, matched or not
	int received = 0;
	// results compared against a pending request
	int checks = 0;
	int value_errors = 0;
	int proto_errors = 0;
	int cycles = 0;

	bf16_div_clkgen clkgen_i (
		.clk (clk),
		.rst (rst)
	);

	bf16_div_top dut_i (
		.clk     (clk),
		.rst     (rst),
		.in_req  (in_req),
		.in_ack  (in_ack),
		.a       (a),
		.b       (b),
		.out_req (out_req),
		.out_ack (out_ack),
		.result  (result)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one lfsr step per bit taken
	function automatic int next_bits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// random sign and fraction with exponent 60 to 190
	function automatic logic [15:0] rand_operand();
		int s;
		int e;
		int f;
		s = next_bits(1);
		e = 60 + next_bits(8) % 131;
		f = next_bits(7);
		return {s[0], e[7:0], f[6:0]};
	endfunction

	// expected quotient word truncated without rounding
	function automatic logic [15:0] bf16_div_ref(input logic [15:0] x, input logic [15:0] y);
		logic sign;
		int ex;
		int ey;
		int num;
		int den;
		int quo;
		int e;
		sign = x[15] ^ y[15];
		ex = int'(x[14:7]);
		ey = int'(y[14:7]);
		// zero exponent is a zero operand
		if (ex == 0 || ey == 0)
			return {sign, 15'd0};
		// hidden one in front of each fraction
		num = (128 + int'(x[6:0])) * 256;
		den = 128 + int'(y[6:0]);
		quo = num / den;
		e = ex - ey + 127;
		// leading one at bit 8 or bit 7
		if (quo >= 256)
			quo = quo / 2;
		else
			e = e - 1;
		if (e <= 0)
			return {sign, 15'd0};
		if (e >= 255)
			return {sign, 8'd254, 7'd127};
		return {sign, e[7:0], quo[6:0]};
	endfunction

	// one four-phase transfer on the input side
	task automatic send_op(input logic [15:0] av, input logic [15:0] bv, input string name);
		int gap;
		gap = next_bits(2);
		repeat (gap) @(posedge clk);
		expect_q.push_back(bf16_div_ref(av, bv));
		name_q.push_back(name);
		sent++;
		a <= av;
		b <= bv;
		in_req <= 1'b1;
		do
			@(posedge clk);
		while (!in_ack);
		in_req <= 1'b0;
		// operands may change only once ack is low again
		do
			@(posedge clk);
		while (in_ack);
	endtask

	// all handshakes quiet after reset
	task automatic check_idle();
		repeat (8)
		begin
			@(posedge clk);
			assert (!in_ack && !out_req)
			else
			begin
				$display("in_ack or out_req went high after reset with no request");
				proto_errors++;
			end
			assert (!dut_i.u_req && !dut_i.u_ack && !dut_i.d_req && !dut_i.d_ack)
			else
			begin
				$display("an inner req or ack went high after reset with no request");
				proto_errors++;
			end
		end
	endtask

	task automatic random_pairs(input int count);
		int i;
		for (i = 0; i < count; i++)
			send_op(rand_operand(), rand_operand(), "random");
	endtask

	// signed zeros including a zero exponent with a nonzero fraction
	task automatic zero_operands();
		send_op(16'h0000, 16'h3f80, "zero_dividend");
		send_op(16'h8000, 16'h4040, "zero_dividend_neg");
		send_op(16'h4049, 16'h0000, "zero_divisor");
		send_op(16'hc049, 16'h8000, "zero_divisor_neg");
		send_op(16'h8000, 16'h0000, "zero_both");
		send_op(16'h8000, 16'h8000, "zero_both_neg");
		send_op(16'h0055, 16'hbf80, "zero_exp_fraction");
	endtask

	// underflow and saturation around their edges
	task automatic range_limits();
		send_op(16'h0080, 16'h7f00, "underflow_deep");
		send_op(16'h8180, 16'h4300, "underflow_neg");
		send_op(16'h0080, 16'h4000, "underflow_edge");
		send_op(16'h00c0, 16'h3f80, "above_underflow");
		send_op(16'h7f7f, 16'h0080, "overflow_deep");
		send_op(16'hff80, 16'h3f80, "overflow_edge");
		send_op(16'h7fff, 16'h3fff, "overflow_exp255");
		send_op(16'h7f00, 16'h3f80, "below_overflow");
	endtask

	// wait for every result and for the output handshake to settle
	task automatic drain_results();
		while (received < sent)
			@(posedge clk);
		while (out_req || out_ack)
			@(posedge clk);
	endtask

	// out_ack held low for 50 cycles while requests keep coming
	task automatic stall_check();
		logic [15:0] held;
		logic seen;
		logic ack_prev;
		int accepted;
		int i;
		held = '0;
		seen = 1'b0;
		ack_prev = 1'b0;
		accepted = 0;
		hold_ack <= 1'b1;
		fork
			begin
				for (i = 0; i < 6; i++)
					send_op(rand_operand(), rand_operand(), "stall");
			end
			begin
				repeat (50)
				begin
					@(posedge clk);
					// count accepted requests by the rise of in_ack
					if (in_ack && !ack_prev)
						accepted++;
					ack_prev = in_ack;
					if (out_req && !seen)
					begin
						held = result;
						seen = 1'b1;
					end
					else if (out_req)
					begin
						assert (result === held)
						else
						begin
							$display("ERROR stall_hold: expected %h, actual %h", held, result);
							value_errors++;
						end
					end
				end
				assert (seen)
				else
				begin
					$display("no result appeared while out_ack was held low");
					proto_errors++;
				end
				// one item per stage
				assert (accepted == 3)
				else
				begin
					$display("pipeline took %0d requests while stalled, 3 expected", accepted);
					proto_errors++;
				end
				assert (in_req && !in_ack)
				else
				begin
					$display("in_ack still acknowledging with the pipeline full");
					proto_errors++;
				end
				hold_ack <= 1'b0;
			end
		join
	endtask

	task automatic check_result();
		logic [15:0] want;
		string name;
		received++;
		assert (expect_q.size() > 0)
		else
		begin
			$display("result %h arrived with no request pending", result);
			proto_errors++;
		end
		if (expect_q.size() > 0)
		begin
			want = expect_q.pop_front();
			name = name_q.pop_front();
			checks++;
			assert (result === want)
			else
			begin
				$display("ERROR %s: expected %h, actual %h", name, want, result);
				value_errors++;
			end
		end
	endtask

	// a result is marked by the rise of out_req
	always @(posedge clk)
	begin
		if (!rst && out_req && !out_req_prev)
			check_result();
		out_req_prev <= out_req;
	end

	// receiver acks after a random delay of 0 to 7 cycles
	initial
	begin : receiver
		int delay;
		out_ack <= 1'b0;
		forever
		begin
			@(posedge clk);
			if (out_req && !hold_ack)
			begin
				delay = next_bits(3);
				repeat (delay) @(posedge clk);
				out_ack <= 1'b1;
				do
					@(posedge clk);
				while (out_req);
				out_ack <= 1'b0;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("checks %0d, value errors %0d, protocol errors %0d",
				checks, value_errors, proto_errors);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial
	begin
		in_req <= 1'b0;
		a <= '0;
		b <= '0;
		hold_ack <= 1'b0;
		@(posedge clk);
		while (rst)
			@(posedge clk);
		check_idle();
		random_pairs(300);
		zero_operands();
		range_limits();
		drain_results();
		stall_check();
		drain_results();
		// late duplicates would show up here
		repeat (20) @(posedge clk);
		assert (received == sent && expect_q.size() == 0)
		else
		begin
			$display("%0d requests sent but %0d results received", sent, received);
			proto_errors++;
		end
		$display("checks %0d, value errors %0d, protocol errors %0d",
			checks, value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== files.f ====
rtl/bf16_div_pkg.sv
rtl/bf16_div_unpack.sv
rtl/bf16_long_div.sv
rtl/bf16_div_normalize.sv
rtl/bf16_div_top.sv
dv/bf16_div_clkgen.sv
dv/bf16_div_tb.sv

// ==== rtl/bf16_div_normalize.sv ====
`timescale 1ns/1ns

module bf16_div_normalize (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     d_req,
	output logic                                     d_ack,
	input  logic [bf16_div_pkg::QUOT_W-1:0]          d_quot,
	input  logic                                     d_sign,
	input  logic signed [bf16_div_pkg::WEXP_W-1:0]   d_exp,
	input  logic                                     d_zero,
	output logic                                     out_req,
	input  logic                                     out_ack,
	output logic [bf16_div_pkg::BF16_W-1:0]          result
);

	// captured quotient and side fields
	logic [bf16_div_pkg::QUOT_W-1:0] quot_q;
	logic signed [bf16_div_pkg::WEXP_W-1:0] exp_q;
	logic sign_q;
	logic zero_q;

	// normalize cycle, then pack cycle
	logic norm_v;
	logic pack_v;
	logic take;

	logic underflow;
	logic saturate;
	logic [bf16_div_pkg::BF16_W-1:0] packed_word;

	assign take = d_req && !d_ack && !norm_v && !pack_v && !out_req;

	// zero or negative exponent
	assign underflow = exp_q[bf16_div_pkg::WEXP_W-1] || (exp_q == '0);
	assign saturate = exp_q >= bf16_div_pkg::MAX_ENC_EXP;

	always_comb
	begin
		// priority: zero operand, underflow, saturation
		if (zero_q || underflow)
			packed_word = {sign_q, {bf16_div_pkg::EXP_W{1'b0}}, {bf16_div_pkg::FRAC_W{1'b0}}};
		else if (saturate)
			packed_word = {sign_q, bf16_div_pkg::SAT_EXP, bf16_div_pkg::SAT_FRAC};
		else
			// truncated, low quotient bits become the fraction
			packed_word = {sign_q, exp_q[bf16_div_pkg::EXP_W-1:0],
				quot_q[bf16_div_pkg::FRAC_W-1:0]};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			d_ack <= 1'b0;
			norm_v <= 1'b0;
			pack_v <= 1'b0;
			out_req <= 1'b0;
		end
		else
		begin
			if (take)
				d_ack <= 1'b1;
			else if (!d_req)
				d_ack <= 1'b0;
			norm_v <= take;
			pack_v <= norm_v;
			// result valid two cycles after capture
			if (pack_v)
				out_req <= 1'b1;
			else if (out_ack)
				out_req <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			quot_q <= d_quot;
			exp_q <= d_exp;
			sign_q <= d_sign;
			zero_q <= d_zero;
		end
		else if (norm_v)
		begin
			// quotient lies in [128, 512), bit 8 decides the leading one
			if (quot_q[bf16_div_pkg::SIG_W])
				quot_q <= quot_q >> 1;
			else
				exp_q <= exp_q - 1'b1;
		end
		// result holds while out_ack is low
		if (pack_v)
			result <= packed_word;
	end

endmodule

// ==== rtl/bf16_div_pkg.sv ====
package bf16_div_pkg;

	// bfloat16 word layout
	localparam int BF16_W = 16;
	localparam int EXP_W = 8;
	localparam int FRAC_W = 7;

	// significand with the hidden one in front of the fraction
	localparam int SIG_W = 8;

	// field positions inside a word
	localparam int SIGN_POS = 15;
	localparam int EXP_MSB = 14;
	localparam int EXP_LSB = 7;

	// working exponent is signed
	// covers -128 up to 382 with headroom
	localparam int WEXP_W = 10;

	// exponent bias, kept at working exponent width
	localparam logic signed [WEXP_W-1:0] BIAS = 10'sd127;

	// saturation starts here
	localparam logic signed [WEXP_W-1:0] MAX_ENC_EXP = 10'sd255;

	// largest finite magnitude the unit emits
	localparam logic [EXP_W-1:0] SAT_EXP = 8'd254;
	localparam logic [FRAC_W-1:0] SAT_FRAC = 7'd127;

	// long division, 16 by 8 bits
	localparam int QUOT_W = 16;

	// radix 16, four quotient bits per step
	localparam int DIGIT_W = 4;
	localparam int DIV_ITER = QUOT_W / DIGIT_W;

	// iteration counter width
	localparam int ITER_W = $clog2(DIV_ITER);

	// partial remainder after the digit shift
	// remainder stays below the divisor, so SIG_W bits plus one digit
	localparam int PREM_W = SIG_W + DIGIT_W;

endpackage

// ==== rtl/bf16_div_top.sv ====
`timescale 1ns/1ns

module bf16_div_top (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              in_req,
	output logic                              in_ack,
	input  logic [bf16_div_pkg::BF16_W-1:0]   a,
	input  logic [bf16_div_pkg::BF16_W-1:0]   b,
	output logic                              out_req,
	input  logic                              out_ack,
	output logic [bf16_div_pkg::BF16_W-1:0]   result
);

	// unpack to long division
	logic u_req;
	logic u_ack;
	logic [bf16_div_pkg::QUOT_W-1:0] u_dividend;
	logic [bf16_div_pkg::SIG_W-1:0] u_divisor;
	logic u_sign;
	logic signed [bf16_div_pkg::WEXP_W-1:0] u_exp;
	logic u_zero;

	// long division to normalize
	logic d_req;
	logic d_ack;
	logic [bf16_div_pkg::QUOT_W-1:0] d_quot;
	logic d_sign;
	logic signed [bf16_div_pkg::WEXP_W-1:0] d_exp;
	logic d_zero;

	// operand fields, sign and exponent difference
	bf16_div_unpack unpack_i (
		.clk        (clk),
		.rst        (rst),
		.in_req     (in_req),
		.in_ack     (in_ack),
		.a          (a),
		.b          (b),
		.u_req      (u_req),
		.u_ack      (u_ack),
		.u_dividend (u_dividend),
		.u_divisor  (u_divisor),
		.u_sign     (u_sign),
		.u_exp      (u_exp),
		.u_zero     (u_zero)
	);

	// quotient significand, four bits per cycle
	bf16_long_div long_div_i (
		.clk        (clk),
		.rst        (rst),
		.u_req      (u_req),
		.u_ack      (u_ack),
		.u_dividend (u_dividend),
		.u_divisor  (u_divisor),
		.u_sign     (u_sign),
		.u_exp      (u_exp),
		.u_zero     (u_zero),
		.d_req      (d_req),
		.d_ack      (d_ack),
		.d_quot     (d_quot),
		.d_sign     (d_sign),
		.d_exp      (d_exp),
		.d_zero     (d_zero)
	);

	// normalize, special cases, pack
	bf16_div_normalize normalize_i (
		.clk     (clk),
		.rst     (rst),
		.d_req   (d_req),
		.d_ack   (d_ack),
		.d_quot  (d_quot),
		.d_sign  (d_sign),
		.d_exp   (d_exp),
		.d_zero  (d_zero),
		.out_req (out_req),
		.out_ack (out_ack),
		.result  (result)
	);

endmodule

// ==== rtl/bf16_div_unpack.sv ====
`timescale 1ns/1ns

module bf16_div_unpack (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     in_req,
	output logic                                     in_ack,
	input  logic [bf16_div_pkg::BF16_W-1:0]          a,
	input  logic [bf16_div_pkg::BF16_W-1:0]          b,
	output logic                                     u_req,
	input  logic                                     u_ack,
	output logic [bf16_div_pkg::QUOT_W-1:0]          u_dividend,
	output logic [bf16_div_pkg::SIG_W-1:0]           u_divisor,
	output logic                                     u_sign,
	output logic signed [bf16_div_pkg::WEXP_W-1:0]   u_exp,
	output logic                                     u_zero
);

	// raw operand pair
	logic [bf16_div_pkg::BF16_W-1:0] a_q;
	logic [bf16_div_pkg::BF16_W-1:0] b_q;

	// operands held, fields formed on the next edge
	logic loaded;
	logic take;

	logic [bf16_div_pkg::EXP_W-1:0] exp_a;
	logic [bf16_div_pkg::EXP_W-1:0] exp_b;
	logic signed [bf16_div_pkg::WEXP_W-1:0] wexp_a;
	logic signed [bf16_div_pkg::WEXP_W-1:0] wexp_b;
	logic hid_a;
	logic hid_b;

	// accept only into an empty slot, and only on a fresh req
	assign take = in_req && !in_ack && !loaded && !u_req;

	assign exp_a = a_q[bf16_div_pkg::EXP_MSB:bf16_div_pkg::EXP_LSB];
	assign exp_b = b_q[bf16_div_pkg::EXP_MSB:bf16_div_pkg::EXP_LSB];

	// zero extend into the signed working width
	assign wexp_a = {{(bf16_div_pkg::WEXP_W - bf16_div_pkg::EXP_W){1'b0}}, exp_a};
	assign wexp_b = {{(bf16_div_pkg::WEXP_W - bf16_div_pkg::EXP_W){1'b0}}, exp_b};

	// zero exponent means zero, so no hidden one there
	assign hid_a = |exp_a;
	assign hid_b = |exp_b;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_ack <= 1'b0;
			loaded <= 1'b0;
			u_req <= 1'b0;
		end
		else
		begin
			// ack follows capture, drops once req is gone
			if (take)
				in_ack <= 1'b1;
			else if (!in_req)
				in_ack <= 1'b0;
			loaded <= take;
			// req one cycle after capture
			if (loaded)
				u_req <= 1'b1;
			else if (u_ack)
				u_req <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			a_q <= a;
			b_q <= b;
		end
		if (loaded)
		begin
			// dividend significand pre-shifted by 8 for the 16 by 8 divide
			u_dividend <= {hid_a, a_q[bf16_div_pkg::FRAC_W-1:0], {bf16_div_pkg::SIG_W{1'b0}}};
			u_divisor <= {hid_b, b_q[bf16_div_pkg::FRAC_W-1:0]};
			u_sign <= a_q[bf16_div_pkg::SIGN_POS] ^ b_q[bf16_div_pkg::SIGN_POS];
			u_exp <= wexp_a - wexp_b + bf16_div_pkg::BIAS;
			// the only place zero operands are detected
			u_zero <= !hid_a || !hid_b;
		end
	end

endmodule

// ==== rtl/bf16_long_div.sv ====
`timescale 1ns/1ns

module bf16_long_div (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     u_req,
	output logic                                     u_ack,
	input  logic [bf16_div_pkg::QUOT_W-1:0]          u_dividend,
	input  logic [bf16_div_pkg::SIG_W-1:0]           u_divisor,
	input  logic                                     u_sign,
	input  logic signed [bf16_div_pkg::WEXP_W-1:0]   u_exp,
	input  logic                                     u_zero,
	output logic                                     d_req,
	input  logic                                     d_ack,
	output logic [bf16_div_pkg::QUOT_W-1:0]          d_quot,
	output logic                                     d_sign,
	output logic signed [bf16_div_pkg::WEXP_W-1:0]   d_exp,
	output logic                                     d_zero
);

	// dividend bits shift out the top while quotient digits shift in below
	logic [bf16_div_pkg::QUOT_W-1:0] work_q;
	logic [bf16_div_pkg::SIG_W-1:0] div_q;
	logic [bf16_div_pkg::SIG_W-1:0] rem_q;

	// control
	logic busy;
	logic done;
	logic take;
	logic [bf16_div_pkg::ITER_W-1:0] iter;

	// one radix 16 step
	logic [bf16_div_pkg::PREM_W-1:0] rem_sh;
	logic [bf16_div_pkg::PREM_W-1:0] mult;
	logic [bf16_div_pkg::PREM_W-1:0] best;
	logic [bf16_div_pkg::PREM_W-1:0] rem_diff;
	logic [bf16_div_pkg::DIGIT_W-1:0] digit;

	assign take = u_req && !u_ack && !busy && !done && !d_req;

	always_comb
	begin
		// bring down the next four dividend bits
		rem_sh = {rem_q, work_q[bf16_div_pkg::QUOT_W-1 -: bf16_div_pkg::DIGIT_W]};
		mult = '0;
		best = '0;
		digit = '0;
		// multiples grow with k, so the last one that fits is the largest
		for (int k = 1; k < (1 << bf16_div_pkg::DIGIT_W); k++)
		begin
			mult = mult + {{bf16_div_pkg::DIGIT_W{1'b0}}, div_q};
			if (mult <= rem_sh)
			begin
				best = mult;
				digit = k[bf16_div_pkg::DIGIT_W-1:0];
			end
		end
		rem_diff = rem_sh - best;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			u_ack <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			d_req <= 1'b0;
			iter <= '0;
		end
		else
		begin
			if (take)
				u_ack <= 1'b1;
			else if (!u_req)
				u_ack <= 1'b0;
			if (take)
			begin
				busy <= 1'b1;
				iter <= '0;
			end
			else if (busy)
			begin
				iter <= iter + 1'b1;
				// last digit this cycle
				if (iter == bf16_div_pkg::DIV_ITER - 1)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
			// req one cycle after the last digit
			if (done)
			begin
				done <= 1'b0;
				d_req <= 1'b1;
			end
			else if (d_ack)
				d_req <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			work_q <= u_dividend;
			div_q <= u_divisor;
			rem_q <= '0;
			// side fields ride along untouched
			d_sign <= u_sign;
			d_exp <= u_exp;
			d_zero <= u_zero;
		end
		else if (busy)
		begin
			work_q <= {work_q[bf16_div_pkg::QUOT_W-bf16_div_pkg::DIGIT_W-1:0], digit};
			rem_q <= rem_diff[bf16_div_pkg::SIG_W-1:0];
		end
	end

	assign d_quot = work_q;

endmodule
